// ==== common/scurvePkg.sv ====
package scurvePkg;

  //////////////////////////////////////////////////////////////////////
  // Scan parameter widths
  //////////////////////////////////////////////////////////////////////

  // Threshold DAC code
  typedef logic [9:0] dacCodeT;

  // Trigger count, also CPT_MAX and Counter_MAX
  typedef logic [15:0] countT;

  // Word pushed to the external FIFO
  typedef logic [15:0] resultWordT;

  // Trigger window length in Clk cycles
  typedef logic [3:0] delayT;

  // ASIC index carried in the header word
  typedef logic [2:0] asicIdxT;

  //////////////////////////////////////////////////////////////////////
  // Result word format
  //////////////////////////////////////////////////////////////////////

  // Header layout: tag, ASIC index, three zero bits, channel
  localparam logic [3:0] HeaderTag = 4'hC;

  // Result FIFO depth and derived widths
  localparam int ResultDepth = 16;
  localparam int ResultPtrWidth = $clog2(ResultDepth);
  typedef logic [ResultPtrWidth-1:0] bufPtrT;
  typedef logic [ResultPtrWidth:0] bufCountT;

  // Scan sequencer FSM
  typedef enum logic [2:0] {
    Idle,
    Header,
    Config,
    WaitConfig,
    Measure,
    Advance,
    Drain,
    Done
  } seqStateT;

endpackage

// ==== common/asicPkg.sv ====
package asicPkg;

  //////////////////////////////////////////////////////////////////////
  // Readout ASIC geometry
  //////////////////////////////////////////////////////////////////////

  localparam int NumChannels = 64;

  // Three discriminators per channel, each with its own mask bank
  localparam int NumDiscriminators = 3;

  // Clk cycles per slow gate tick in count mode
  localparam int GateDivide = 50;
  localparam int GateDivWidth = $clog2(GateDivide);

  // Channel number
  typedef logic [$clog2(NumChannels)-1:0] channelT;

  // One-hot charge injection vector
  typedef logic [NumChannels-1:0] chanVecT;

  // Discriminator mask, bank d holds bits d*64 up to d*64+63, set bit masks
  typedef logic [NumDiscriminators*NumChannels-1:0] maskT;

  // Gate tick divider counter
  typedef logic [GateDivWidth-1:0] gateDivT;

endpackage

// ==== scanSequencer/scanSequencer.sv ====
`timescale 1ns/10ps

module scanSequencer
  import scurvePkg::*, asicPkg::*;
(
  input  logic       Clk,
  input  logic       reset_n,
  input  logic       Test_Start,
  // High selects a single channel scan, low walks all 64
  input  logic       Single_or_64Chn,
  input  channelT    SingleTestChannel,
  input  logic       Ctest_or_Input,
  input  logic       UnmaskAllChannel,
  input  dacCodeT    StartDac,
  input  dacCodeT    EndDac,
  input  dacCodeT    DacStep,
  input  asicIdxT    TestAsicNumber,
  input  logic       MicrorocConfigurationDone,
  input  logic       Data_Transmit_Done,
  input  logic       bufferSpace,
  input  logic       bufferEmpty,
  input  logic       pointDone,
  output logic       pointStart,
  output resultWordT wordData,
  output logic       wordWrite,
  output chanVecT    Microroc_CTest_Chn_Out,
  output dacCodeT    Microroc_10bit_DAC_Out,
  output maskT       Microroc_Discriminator_Mask,
  output logic       SlowControlParameterLoadStart,
  output logic       Force_Ext_RAZ,
  output logic       SCurve_Test_Done
);

  seqStateT    state;
  channelT     channel;
  logic        startSync1;
  logic        startSync2;
  logic        startPulse;
  logic        pointBusy;
  // One extra bit so the step never wraps past 1023
  logic [10:0] nextDac;
  logic        lastPoint;
  logic        lastChannel;

  // Injection bit, always on in 64-channel mode
  function automatic chanVecT injectVector(channelT ch, logic enable);
    chanVecT vec;
    vec = '0;
    vec[ch] = enable;
    return vec;
  endfunction

  // Unmask the three discriminators of the channel under test
  function automatic maskT maskVector(channelT ch, logic unmaskAll);
    maskT mask;
    mask = unmaskAll ? '0 : '1;
    for (int d = 0; d < NumDiscriminators; d++) begin
      mask[d*NumChannels + int'(ch)] = 1'b0;
    end
    return mask;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Start edge detect
  //////////////////////////////////////////////////////////////////////

  // Pulse lands two cycles after Test_Start rises
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      startSync1 <= 1'b0;
      startSync2 <= 1'b0;
      startPulse <= 1'b0;
    end else begin
      startSync1 <= Test_Start;
      startSync2 <= startSync1;
      startPulse <= startSync1 & ~startSync2;
    end
  end

  assign nextDac = {1'b0, Microroc_10bit_DAC_Out} + {1'b0, DacStep};
  // Zero step ends the channel after one point
  assign lastPoint = (DacStep == '0) || (nextDac > {1'b0, EndDac});
  assign lastChannel = Single_or_64Chn || (channel == channelT'(NumChannels - 1));

  //////////////////////////////////////////////////////////////////////
  // Scan FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= Idle;
      channel <= '0;
      pointStart <= 1'b0;
      Microroc_CTest_Chn_Out <= '0;
      Microroc_10bit_DAC_Out <= '0;
      Microroc_Discriminator_Mask <= '1;
    end else begin
      pointStart <= 1'b0;
      case (state)
        Idle: begin
          if (startPulse) begin
            channel <= Single_or_64Chn ? SingleTestChannel : '0;
            state <= Header;
          end
        end
        // Header goes out this cycle, config for the first point is loaded
        Header: begin
          if (bufferSpace) begin
            Microroc_10bit_DAC_Out <= StartDac;
            Microroc_CTest_Chn_Out <= injectVector(channel, !Single_or_64Chn || Ctest_or_Input);
            Microroc_Discriminator_Mask <= maskVector(channel, UnmaskAllChannel);
            state <= Config;
          end
        end
        Config: state <= WaitConfig;
        WaitConfig: begin
          if (MicrorocConfigurationDone) begin
            pointStart <= 1'b1;
            state <= Measure;
          end
        end
        Measure: begin
          if (pointDone) begin
            state <= Advance;
          end
        end
        // Hold until the buffer can take the next point's word
        Advance: begin
          if (bufferSpace) begin
            if (!lastPoint) begin
              Microroc_10bit_DAC_Out <= nextDac[9:0];
              state <= Config;
            end else if (!lastChannel) begin
              channel <= channel + 1'b1;
              state <= Header;
            end else begin
              state <= Drain;
            end
          end
        end
        Drain: begin
          if (bufferEmpty && Data_Transmit_Done) begin
            state <= Done;
          end
        end
        // Park the ASIC with everything masked
        Done: begin
          Microroc_CTest_Chn_Out <= '0;
          Microroc_Discriminator_Mask <= '1;
          state <= Idle;
        end
        default: state <= Idle;
      endcase
    end
  end

  assign wordWrite = (state == Header) && bufferSpace;
  assign wordData = {HeaderTag, TestAsicNumber, 3'b000, channel};
  assign SlowControlParameterLoadStart = (state == Config);
  assign Force_Ext_RAZ = (state == Measure);
  assign SCurve_Test_Done = (state == Done);

  // Point in flight from pointStart up to the counter's pointDone
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      pointBusy <= 1'b0;
    end else if (pointStart) begin
      pointBusy <= 1'b1;
    end else if (pointDone) begin
      pointBusy <= 1'b0;
    end
  end

  pointStartIdle: assert property (@(posedge Clk) disable iff (!reset_n)
    pointStart |-> !pointBusy);

endmodule

// ==== triggerCounter/triggerCounter.sv ====
`timescale 1ns/10ps

module triggerCounter
  import scurvePkg::*, asicPkg::*;
(
  input  logic  Clk,
  input  logic  reset_n,
  // High for trigger efficiency, low for count efficiency
  input  logic  TriggerEfficiencyOrCountEfficiency,
  input  logic  CLK_EXT,
  input  logic  out_trigger0b,
  input  logic  out_trigger1b,
  input  logic  out_trigger2b,
  input  logic  pointStart,
  input  countT CPT_MAX,
  input  countT Counter_MAX,
  input  delayT TriggerDelay,
  output countT pointCount,
  output logic  pointCountValid,
  output logic  pointDone
);

  logic [2:0] trigMeta;
  logic [2:0] trigSync;
  logic [2:0] extSync;
  logic       triggerNow;
  logic       triggerPrev;
  logic       triggerFall;
  logic       countedEdge;
  logic       windowClose;
  logic       trigDone;
  logic       busy;
  logic       windowHit;
  logic       gateOpen;
  countT      hitCount;
  countT      edgeCount;
  countT      tickCount;
  delayT      windowCnt;
  gateDivT    divCnt;

  // Synchronizers, trigger lines idle high
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      trigMeta <= '1;
      trigSync <= '1;
      triggerPrev <= 1'b0;
      extSync <= '0;
    end else begin
      trigMeta <= {out_trigger2b, out_trigger1b, out_trigger0b};
      trigSync <= trigMeta;
      triggerPrev <= triggerNow;
      extSync <= {extSync[1:0], CLK_EXT};
    end
  end

  // Trigger when all three discriminators are low
  assign triggerNow = (trigSync == 3'b000);
  assign triggerFall = triggerNow && !triggerPrev;
  // Edges past CPT_MAX are ignored
  assign countedEdge = extSync[1] && !extSync[2] && (edgeCount != CPT_MAX);
  // A new edge also closes a still open window
  assign windowClose = (windowCnt == delayT'(1)) || (countedEdge && (windowCnt != '0));
  assign trigDone = (edgeCount == CPT_MAX) && (windowCnt == '0);
  assign pointCount = hitCount;

  //////////////////////////////////////////////////////////////////////
  // Point measurement
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      busy <= 1'b0;
      hitCount <= '0;
      edgeCount <= '0;
      windowCnt <= '0;
      windowHit <= 1'b0;
      gateOpen <= 1'b0;
      divCnt <= '0;
      tickCount <= '0;
      pointDone <= 1'b0;
      pointCountValid <= 1'b0;
    end else begin
      pointDone <= 1'b0;
      pointCountValid <= 1'b0;
      if (pointStart) begin
        busy <= 1'b1;
        hitCount <= '0;
        edgeCount <= '0;
        windowCnt <= '0;
        windowHit <= 1'b0;
        // Gate opens the cycle after pointStart
        gateOpen <= !TriggerEfficiencyOrCountEfficiency;
        divCnt <= '0;
        tickCount <= '0;
      end else if (busy && TriggerEfficiencyOrCountEfficiency) begin
        // One count per window that saw a trigger
        if (windowClose && (windowHit || triggerNow) && (hitCount != '1)) begin
          hitCount <= hitCount + 1'b1;
        end
        if (countedEdge) begin
          edgeCount <= edgeCount + 1'b1;
          windowCnt <= TriggerDelay;
          windowHit <= triggerNow;
        end else if (windowCnt != '0) begin
          windowCnt <= windowCnt - 1'b1;
          windowHit <= windowHit || triggerNow;
        end
        if (trigDone) begin
          busy <= 1'b0;
          pointDone <= 1'b1;
          pointCountValid <= 1'b1;
        end
      end else if (busy) begin
        // Count mode, saturating count of trigger falling edges
        if (gateOpen && triggerFall && (hitCount != '1)) begin
          hitCount <= hitCount + 1'b1;
        end
        if (gateOpen) begin
          if (divCnt == gateDivT'(GateDivide - 1)) begin
            divCnt <= '0;
            tickCount <= tickCount + 1'b1;
            if (tickCount == Counter_MAX - 1'b1) begin
              gateOpen <= 1'b0;
            end
          end else begin
            divCnt <= divCnt + 1'b1;
          end
        end else begin
          busy <= 1'b0;
          pointDone <= 1'b1;
          pointCountValid <= 1'b1;
        end
      end
    end
  end

  // Trigger mode never reports more hit windows than injection edges
  doneCarriesCount: assert property (@(posedge Clk) disable iff (!reset_n)
    pointDone |-> pointCountValid &&
      (!TriggerEfficiencyOrCountEfficiency || (pointCount <= CPT_MAX)));

endmodule

// ==== design/resultBuffer.sv ====
`timescale 1ns/10ps

module resultBuffer
  import scurvePkg::*;
(
  input  logic       Clk,
  input  logic       reset_n,
  input  resultWordT wordData,
  input  logic       wordWrite,
  input  countT      pointCount,
  input  logic       pointCountValid,
  input  logic       ExternalDataFifoFull,
  output resultWordT SCurveTestDataout,
  output logic       SCurveTestDataoutEnable,
  output logic       bufferSpace,
  output logic       bufferEmpty
);

  resultWordT mem [ResultDepth];
  bufPtrT     wrPtr;
  bufPtrT     rdPtr;
  bufCountT   fill;
  logic       push;
  logic       pop;
  resultWordT pushData;

  // Header and count strobes share one write port
  assign push = wordWrite || pointCountValid;
  assign pushData = wordWrite ? wordData : resultWordT'(pointCount);

  assign bufferEmpty = (fill == '0);
  // Room for a header plus one count word
  assign bufferSpace = (fill <= bufCountT'(ResultDepth - 2));

  // Drain straight from the head entry while the downstream FIFO has room
  assign pop = !bufferEmpty && !ExternalDataFifoFull;
  assign SCurveTestDataout = mem[rdPtr];
  assign SCurveTestDataoutEnable = pop;

  always_ff @(posedge Clk) begin
    if (push) begin
      mem[wrPtr] <= pushData;
    end
  end

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      wrPtr <= '0;
      rdPtr <= '0;
      fill <= '0;
    end else begin
      if (push) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (pop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({push, pop})
        2'b10: fill <= fill + 1'b1;
        2'b01: fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
    end
  end

  // Sequencer flow control keeps both of these from happening
  noOverflow: assert property (@(posedge Clk) disable iff (!reset_n)
    push |-> (fill != bufCountT'(ResultDepth)) && !(wordWrite && pointCountValid));

endmodule

// ==== design/sCurveTestTop.sv ====
`timescale 1ns/10ps

module sCurveTestTop
  import scurvePkg::*, asicPkg::*;
(
  input  logic       Clk,
  input  logic       reset_n,
  input  logic       TriggerEfficiencyOrCountEfficiency,
  // Scan control
  input  logic       Test_Start,
  input  logic       Single_or_64Chn,
  input  channelT    SingleTestChannel,
  input  logic       Ctest_or_Input,
  input  logic       UnmaskAllChannel,
  input  countT      CPT_MAX,
  input  countT      Counter_MAX,
  input  dacCodeT    StartDac,
  input  dacCodeT    EndDac,
  input  dacCodeT    DacStep,
  input  delayT      TriggerDelay,
  input  asicIdxT    TestAsicNumber,
  // External data FIFO
  output resultWordT SCurveTestDataout,
  output logic       SCurveTestDataoutEnable,
  input  logic       ExternalDataFifoFull,
  // ASIC slow control
  input  logic       MicrorocConfigurationDone,
  output chanVecT    Microroc_CTest_Chn_Out,
  output dacCodeT    Microroc_10bit_DAC_Out,
  output maskT       Microroc_Discriminator_Mask,
  output logic       SlowControlParameterLoadStart,
  output logic       Force_Ext_RAZ,
  // ASIC pins
  input  logic       CLK_EXT,
  input  logic       out_trigger0b,
  input  logic       out_trigger1b,
  input  logic       out_trigger2b,
  // Completion
  output logic       SCurve_Test_Done,
  input  logic       Data_Transmit_Done
);

  logic       pointStart;
  logic       pointDone;
  logic       pointCountValid;
  countT      pointCount;
  resultWordT wordData;
  logic       wordWrite;
  logic       bufferSpace;
  logic       bufferEmpty;

  //////////////////////////////////////////////////////////////////////
  // Decode, execute, result
  //////////////////////////////////////////////////////////////////////

  scanSequencer decode (
    .Clk                          (Clk),
    .reset_n                      (reset_n),
    .Test_Start                   (Test_Start),
    .Single_or_64Chn              (Single_or_64Chn),
    .SingleTestChannel            (SingleTestChannel),
    .Ctest_or_Input               (Ctest_or_Input),
    .UnmaskAllChannel             (UnmaskAllChannel),
    .StartDac                     (StartDac),
    .EndDac                       (EndDac),
    .DacStep                      (DacStep),
    .TestAsicNumber               (TestAsicNumber),
    .MicrorocConfigurationDone    (MicrorocConfigurationDone),
    .Data_Transmit_Done           (Data_Transmit_Done),
    .bufferSpace                  (bufferSpace),
    .bufferEmpty                  (bufferEmpty),
    .pointDone                    (pointDone),
    .pointStart                   (pointStart),
    .wordData                     (wordData),
    .wordWrite                    (wordWrite),
    .Microroc_CTest_Chn_Out       (Microroc_CTest_Chn_Out),
    .Microroc_10bit_DAC_Out       (Microroc_10bit_DAC_Out),
    .Microroc_Discriminator_Mask  (Microroc_Discriminator_Mask),
    .SlowControlParameterLoadStart(SlowControlParameterLoadStart),
    .Force_Ext_RAZ                (Force_Ext_RAZ),
    .SCurve_Test_Done             (SCurve_Test_Done)
  );

  triggerCounter execute (
    .Clk                               (Clk),
    .reset_n                           (reset_n),
    .TriggerEfficiencyOrCountEfficiency(TriggerEfficiencyOrCountEfficiency),
    .CLK_EXT                           (CLK_EXT),
    .out_trigger0b                     (out_trigger0b),
    .out_trigger1b                     (out_trigger1b),
    .out_trigger2b                     (out_trigger2b),
    .pointStart                        (pointStart),
    .CPT_MAX                           (CPT_MAX),
    .Counter_MAX                       (Counter_MAX),
    .TriggerDelay                      (TriggerDelay),
    .pointCount                        (pointCount),
    .pointCountValid                   (pointCountValid),
    .pointDone                         (pointDone)
  );

  resultBuffer result (
    .Clk                    (Clk),
    .reset_n                (reset_n),
    .wordData               (wordData),
    .wordWrite              (wordWrite),
    .pointCount             (pointCount),
    .pointCountValid        (pointCountValid),
    .ExternalDataFifoFull   (ExternalDataFifoFull),
    .SCurveTestDataout      (SCurveTestDataout),
    .SCurveTestDataoutEnable(SCurveTestDataoutEnable),
    .bufferSpace            (bufferSpace),
    .bufferEmpty            (bufferEmpty)
  );

endmodule

// ==== verification/sCurveTestTb.sv ====
`timescale 1ns/10ps

module sCurveTestTb
  import scurvePkg::*, asicPkg::*;
();

  // Scan settings shared by every run
  localparam int CptMax = 3;
  localparam int CountMax = 4;
  localparam int TrigDelay = 4;
  // CLK_EXT half period in Clk cycles
  localparam int ExtHalfPeriod = 6;
  // Trigger pulses per count mode point
  localparam int BurstPulses = 5;

  // Wide enough for the discriminator mask
  typedef logic [NumDiscriminators*NumChannels-1:0] checkValT;

  logic       Clk = 1'b0;
  logic       reset_n;
  logic       TriggerEfficiencyOrCountEfficiency;
  logic       Test_Start;
  logic       Single_or_64Chn;
  channelT    SingleTestChannel;
  logic       Ctest_or_Input;
  logic       UnmaskAllChannel;
  countT      CPT_MAX;
  countT      Counter_MAX;
  dacCodeT    StartDac;
  dacCodeT    EndDac;
  dacCodeT    DacStep;
  delayT      TriggerDelay;
  asicIdxT    TestAsicNumber;
  resultWordT SCurveTestDataout;
  logic       SCurveTestDataoutEnable;
  logic       ExternalDataFifoFull;
  logic       MicrorocConfigurationDone;
  chanVecT    Microroc_CTest_Chn_Out;
  dacCodeT    Microroc_10bit_DAC_Out;
  maskT       Microroc_Discriminator_Mask;
  logic       SlowControlParameterLoadStart;
  logic       Force_Ext_RAZ;
  logic       CLK_EXT;
  logic       out_trigger0b;
  logic       out_trigger1b;
  logic       out_trigger2b;
  logic       SCurve_Test_Done;
  logic       Data_Transmit_Done;

  // Expected output stream and scan bookkeeping
  resultWordT expectedQ[$];
  int         cycleCount = 0;
  int         cycleLimit = 2000;
  int         errorCount = 0;
  int         loadCount = 0;
  int         doneCount = 0;
  int         firstChan = 0;
  int         pointsPerChan = 1;
  int         scanStart = 0;
  int         scanStep = 0;
  logic       pressureOn = 1'b0;

  sCurveTestTop uut (.*);

  always #50 Clk = ~Clk;

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Discriminator threshold of the ASIC model
  function automatic int thresholdFor(int ch);
    return 200 + 4 * ch;
  endfunction

  // Tag, ASIC index, three zero bits, channel
  function automatic resultWordT headerWord(int asic, int ch);
    return {HeaderTag, 3'(asic), 3'b000, 6'(ch)};
  endfunction

  // Everything masked except the three discriminators of ch
  function automatic maskT maskFor(int ch);
    maskT mask;
    mask = '1;
    for (int d = 0; d < NumDiscriminators; d++) begin
      mask[d * NumChannels + ch] = 1'b0;
    end
    return mask;
  endfunction

  function automatic int pointsFor(int dacFrom, int dacTo, int step);
    if (step == 0) begin
      return 1;
    end
    return (dacTo - dacFrom) / step + 1;
  endfunction

  // Expected words of one scan in output order
  function automatic void buildExpected(logic trigMode, logic single, int chan, int asic,
                                        int dacFrom, int dacTo, int step);
    int lastCh;
    int code;
    lastCh = single ? chan : NumChannels - 1;
    for (int ch = (single ? chan : 0); ch <= lastCh; ch++) begin
      expectedQ.push_back(headerWord(asic, ch));
      for (int p = 0; p < pointsFor(dacFrom, dacTo, step); p++) begin
        code = dacFrom + p * step;
        if (!trigMode) begin
          expectedQ.push_back(resultWordT'(BurstPulses));
        end else if (code < thresholdFor(ch)) begin
          expectedQ.push_back(resultWordT'(CptMax));
        end else begin
          expectedQ.push_back('0);
        end
      end
    end
  endfunction

  // Rough scan length in cycles, used for the timeout
  function automatic int scanCycles(logic trigMode, logic single, int dacFrom, int dacTo,
                                    int step);
    int perPoint;
    int channels;
    channels = single ? 1 : NumChannels;
    perPoint = trigMode ? (CptMax + 2) * 2 * ExtHalfPeriod + 30 : CountMax * GateDivide + 30;
    return channels * (pointsFor(dacFrom, dacTo, step) * perPoint + 20) + 100;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Checking
  //////////////////////////////////////////////////////////////////////

  task automatic endInFailure();
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic checkEqual(input checkValT actual, input checkValT expected,
                            input string what);
    if (actual !== expected) begin
      errorCount++;
      $display("FAIL at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
      endInFailure();
    end
  endtask

  // Comparing process, one expected word per output strobe
  always @(negedge Clk) begin
    if (reset_n && SCurveTestDataoutEnable) begin
      checkEqual(checkValT'(ExternalDataFifoFull), '0, "output strobe while FIFO full");
      if (expectedQ.size() == 0) begin
        $display("Error: DUT sent word %h after the expected stream had ended",
                 SCurveTestDataout);
        endInFailure();
      end else begin
        checkEqual(checkValT'(SCurveTestDataout), checkValT'(expectedQ.pop_front()),
                   "result word");
      end
    end
  end

  // Settings handed to the slow control loader
  always @(negedge Clk) begin : loadMonitor
    int ch;
    int code;
    if (reset_n && SlowControlParameterLoadStart) begin
      ch = firstChan + loadCount / pointsPerChan;
      code = scanStart + (loadCount % pointsPerChan) * scanStep;
      checkEqual(checkValT'(Microroc_Discriminator_Mask), checkValT'(maskFor(ch)),
                 "mask at load start");
      checkEqual(checkValT'(Microroc_10bit_DAC_Out), checkValT'(code), "DAC code at load start");
      checkEqual(checkValT'(Microroc_CTest_Chn_Out), checkValT'(chanVecT'(1) << ch),
                 "injection vector at load start");
      // RAZ only belongs to the measurement
      checkEqual(checkValT'(Force_Ext_RAZ), '0, "RAZ at load start");
      loadCount++;
    end
  end

  // Completion only once the whole stream is out
  always @(negedge Clk) begin
    if (reset_n && SCurve_Test_Done) begin
      doneCount++;
      checkEqual(checkValT'(expectedQ.size()), '0, "words outstanding at completion");
      checkEqual(checkValT'(Data_Transmit_Done), checkValT'(1), "transmit done at completion");
    end
  end

  always @(posedge Clk) begin
    cycleCount++;
    if (cycleCount > cycleLimit) begin
      $display("Timeout: the scans did not finish within %0d clock cycles", cycleLimit);
      endInFailure();
    end
  end

  //////////////////////////////////////////////////////////////////////
  // ASIC models
  //////////////////////////////////////////////////////////////////////

  // Slow control loader, done after 1 to 8 cycles
  initial begin : asicConfigModel
    int delayCycles;
    MicrorocConfigurationDone = 1'b0;
    forever begin
      @(negedge Clk);
      if (SlowControlParameterLoadStart) begin
        delayCycles = 1 + ($urandom % 8);
        @(posedge Clk);
        #10 MicrorocConfigurationDone = 1'b0;
        repeat (delayCycles) @(posedge Clk);
        #10 MicrorocConfigurationDone = 1'b1;
      end
    end
  end

  // Injection clock and discriminator outputs
  initial begin : triggerModel
    int extTicks;
    int burstWait;
    int burstLeft;
    int activeCh;
    logic extRose;
    logic razPrev;
    logic trigLow;
    dacCodeT dacSeen;
    CLK_EXT = 1'b0;
    out_trigger0b = 1'b1;
    out_trigger1b = 1'b1;
    out_trigger2b = 1'b1;
    extTicks = 0;
    burstWait = 0;
    burstLeft = 0;
    extRose = 1'b0;
    razPrev = 1'b0;
    forever begin
      @(negedge Clk);
      dacSeen = Microroc_10bit_DAC_Out;
      activeCh = -1;
      for (int i = 0; i < NumChannels; i++) begin
        if (Microroc_CTest_Chn_Out[i]) begin
          activeCh = i;
        end
      end
      // Count mode burst follows the start of a measurement
      if (!TriggerEfficiencyOrCountEfficiency && Force_Ext_RAZ && !razPrev) begin
        burstWait = 3;
        burstLeft = BurstPulses;
      end
      razPrev = Force_Ext_RAZ;
      @(posedge Clk);
      #10;
      trigLow = 1'b0;
      if (TriggerEfficiencyOrCountEfficiency) begin
        // Fires one cycle after an injection edge while below threshold
        if (extRose && activeCh >= 0 && int'(dacSeen) < thresholdFor(activeCh)) begin
          trigLow = 1'b1;
        end
      end else if (burstLeft > 0) begin
        if (burstWait == 0) begin
          trigLow = 1'b1;
          burstLeft--;
          burstWait = 3;
        end else begin
          burstWait--;
        end
      end
      extRose = 1'b0;
      extTicks++;
      if (extTicks == ExtHalfPeriod) begin
        extTicks = 0;
        CLK_EXT = ~CLK_EXT;
        extRose = CLK_EXT;
      end
      out_trigger0b = !trigLow;
      out_trigger1b = !trigLow;
      out_trigger2b = !trigLow;
    end
  end

  // External FIFO full in random runs of up to 30 cycles
  initial begin : pressureModel
    int runLeft;
    ExternalDataFifoFull = 1'b0;
    runLeft = 0;
    forever begin
      @(posedge Clk);
      #10;
      if (!pressureOn) begin
        ExternalDataFifoFull = 1'b0;
        runLeft = 0;
      end else if (runLeft > 0) begin
        runLeft--;
      end else if (ExternalDataFifoFull) begin
        ExternalDataFifoFull = 1'b0;
        runLeft = $urandom % 8;
      end else begin
        ExternalDataFifoFull = 1'b1;
        runLeft = $urandom % 30;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Scan runs
  //////////////////////////////////////////////////////////////////////

  task automatic runScan(input logic trigMode, input logic single, input int chan,
                         input int asic, input int dacFrom, input int dacTo, input int step,
                         input logic withPressure);
    @(posedge Clk);
    #10;
    TriggerEfficiencyOrCountEfficiency = trigMode;
    Single_or_64Chn = single;
    SingleTestChannel = channelT'(chan);
    TestAsicNumber = asicIdxT'(asic);
    StartDac = dacCodeT'(dacFrom);
    EndDac = dacCodeT'(dacTo);
    DacStep = dacCodeT'(step);
    Data_Transmit_Done = 1'b0;
    pressureOn = withPressure;
    firstChan = single ? chan : 0;
    pointsPerChan = pointsFor(dacFrom, dacTo, step);
    scanStart = dacFrom;
    scanStep = step;
    loadCount = 0;
    doneCount = 0;
    cycleLimit += 2 * scanCycles(trigMode, single, dacFrom, dacTo, step);
    buildExpected(trigMode, single, chan, asic, dacFrom, dacTo, step);
    // Start request held a few cycles, the DUT acts on its edge
    @(posedge Clk);
    #10 Test_Start = 1'b1;
    repeat (3) @(posedge Clk);
    #10 Test_Start = 1'b0;
    while (expectedQ.size() != 0) begin
      @(posedge Clk);
    end
    // Transmit done lags the last word, completion has to wait for it
    repeat (4) @(posedge Clk);
    #10;
    Data_Transmit_Done = 1'b1;
    pressureOn = 1'b0;
    while (doneCount == 0) begin
      @(posedge Clk);
    end
    // Look for a stray second completion pulse
    repeat (5) @(posedge Clk);
    checkEqual(checkValT'(doneCount), checkValT'(1), "completion pulses per run");
    checkEqual(checkValT'(loadCount), checkValT'((single ? 1 : NumChannels) * pointsPerChan),
               "load starts per run");
  endtask

  initial begin : mainSequence
    int seedValue;
    seedValue = $urandom(42);
    reset_n = 1'b0;
    Test_Start = 1'b0;
    TriggerEfficiencyOrCountEfficiency = 1'b1;
    Single_or_64Chn = 1'b1;
    SingleTestChannel = '0;
    Ctest_or_Input = 1'b1;
    UnmaskAllChannel = 1'b0;
    CPT_MAX = countT'(CptMax);
    Counter_MAX = countT'(CountMax);
    StartDac = '0;
    EndDac = '0;
    DacStep = '0;
    TriggerDelay = delayT'(TrigDelay);
    TestAsicNumber = '0;
    Data_Transmit_Done = 1'b0;
    repeat (5) @(posedge Clk);
    #10 reset_n = 1'b1;

    // Channel 5, threshold 220 sits inside the sweep
    runScan(1'b1, 1'b1, 5, 2, 190, 230, 10, 1'b0);
    // Count mode, every point sees the full burst
    runScan(1'b0, 1'b1, 9, 2, 100, 130, 15, 1'b0);
    // All channels, two codes each
    runScan(1'b1, 1'b0, 0, 5, 300, 310, 10, 1'b0);
    // Long sweep under external FIFO back pressure
    runScan(1'b1, 1'b1, 12, 1, 150, 300, 5, 1'b1);
    runScan(1'b1, 1'b1, 5, 7, 190, 230, 10, 1'b0);

    if (errorCount == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      endInFailure();
    end
  end

endmodule

// ==== sCurveTest.f ====
common/scurvePkg.sv
common/asicPkg.sv
scanSequencer/scanSequencer.sv
triggerCounter/triggerCounter.sv
design/resultBuffer.sv
design/sCurveTestTop.sv
verification/sCurveTestTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the sCurveTest testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
  --top-module sCurveTestTb -f sCurveTest.f --Mdir obj_dir -o sCurveTestSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sCurveTestSim > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q "Result: FAILED" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi

if [ $simStatus -ne 0 ]; then
  echo "Simulator exited with status $simStatus"
  exit 1
fi

exit 0
